/* hdl/asi_pkg.sv */
package asi_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int XLEN = 32;                       // Data path width
    localparam int XL   = XLEN - 1;                 // Top bit index

    typedef logic [6:0] asi_uop_t;                  // Class [6:5], function [4:0]

    // Instruction classes
    localparam logic [1:0] ASI_CLS_NONE = 2'b00;
    localparam logic [1:0] ASI_CLS_AES  = 2'b01;
    localparam logic [1:0] ASI_CLS_SHA2 = 2'b10;
    localparam logic [1:0] ASI_CLS_SHA3 = 2'b11;

    // ----------------------------------------------------------
    // Micro-op codes
    // ----------------------------------------------------------
    localparam asi_uop_t ASI_SHA3_XY   = {ASI_CLS_SHA3, 5'd0};
    localparam asi_uop_t ASI_SHA3_X1   = {ASI_CLS_SHA3, 5'd1};
    localparam asi_uop_t ASI_SHA3_X2   = {ASI_CLS_SHA3, 5'd2};
    localparam asi_uop_t ASI_SHA3_X4   = {ASI_CLS_SHA3, 5'd3};
    localparam asi_uop_t ASI_SHA3_YX   = {ASI_CLS_SHA3, 5'd4};

    localparam asi_uop_t ASI_SHA256_S0 = {ASI_CLS_SHA2, 5'd0};  // Small sigma 0
    localparam asi_uop_t ASI_SHA256_S1 = {ASI_CLS_SHA2, 5'd1};  // Small sigma 1
    localparam asi_uop_t ASI_SHA256_S2 = {ASI_CLS_SHA2, 5'd2};  // Big sigma 0
    localparam asi_uop_t ASI_SHA256_S3 = {ASI_CLS_SHA2, 5'd3};  // Big sigma 1

    localparam asi_uop_t ASI_AES_ENCS  = {ASI_CLS_AES, 5'b00000};
    localparam asi_uop_t ASI_AES_ENCM  = {ASI_CLS_AES, 5'b00001};  // Bit 0 is mix
    localparam asi_uop_t ASI_AES_DECS  = {ASI_CLS_AES, 5'b00010};  // Bit 1 is decrypt
    localparam asi_uop_t ASI_AES_DECM  = {ASI_CLS_AES, 5'b00011};

    // ----------------------------------------------------------
    // Two readings of one micro-op word
    // ----------------------------------------------------------
    typedef struct packed {
        logic [1:0] cls;                            // Class
        logic [2:0] rsvd;                           // Must be zero
        logic       dec;                            // Inverse transform
        logic       mix;                            // MixColumns, else SubBytes
    } asi_aes_view_t;

    typedef struct packed {
        logic [1:0] cls;
        logic [4:0] fn;                             // Function number
    } asi_sha_view_t;

    typedef union packed {
        asi_aes_view_t aes_view;
        asi_sha_view_t sha_view;
    } asi_uop_u;

    // One-hot SHA3 select, bit positions below. XY is the plain case
    typedef logic [4:0] sha3_fn_t;
    localparam int SHA3_FN_X1 = 1;
    localparam int SHA3_FN_X2 = 2;
    localparam int SHA3_FN_X4 = 3;
    localparam int SHA3_FN_YX = 4;

    typedef struct packed {
        logic       sel_aes;                        // Class selects, at most one set
        logic       sel_sha2;
        logic       sel_sha3;
        logic       illegal;                        // Unknown code, result is zero
        sha3_fn_t   sha3_fn;
        logic [1:0] sha2_ss;                        // Which sigma
        logic       aes_dec;
        logic       aes_mix;
    } asi_op_t;

endpackage

/* hdl/asi_decode.sv */
`timescale 1ns/10ps

module asi_decode (
    input  logic              valid,                // Instruction present
    input  asi_pkg::asi_uop_t uop,                  // Raw micro-op
    output asi_pkg::asi_op_t  op                    // Decoded controls
);
    import asi_pkg::*;

    asi_uop_u uop_u;                                // Union view of uop
    logic     sha2_ok;                              // Function in range
    logic     sha3_ok;
    logic     aes_ok;                               // Reserved bits clear

    assign uop_u   = uop;
    assign sha2_ok = uop_u.sha_view.fn < 5'd4;
    assign sha3_ok = uop_u.sha_view.fn < 5'd5;
    assign aes_ok  = uop_u.aes_view.rsvd == 3'b000;

    always_comb begin
        op         = '0;
        op.sha2_ss = uop_u.sha_view.fn[1:0];        // Pass-through fields
        op.aes_dec = uop_u.aes_view.dec;
        op.aes_mix = uop_u.aes_view.mix;
        if (valid) begin
            case (uop_u.sha_view.cls)
                ASI_CLS_AES: begin
                    op.sel_aes = aes_ok;
                    op.illegal = !aes_ok;
                end
                ASI_CLS_SHA2: begin
                    op.sel_sha2 = sha2_ok;
                    op.illegal  = !sha2_ok;
                end
                ASI_CLS_SHA3: begin
                    op.sel_sha3 = sha3_ok;
                    op.illegal  = !sha3_ok;
                    if (sha3_ok) begin
                        op.sha3_fn = sha3_fn_t'(5'd1 << uop_u.sha_view.fn[2:0]);  // One-hot
                    end
                end
                ASI_CLS_NONE: op.illegal = 1'b1;    // Nothing lives here
            endcase
        end
    end

    // One class per valid instruction, none without one
    always_comb begin
        a_one_class: assert final (valid ?
                $onehot({op.sel_aes, op.sel_sha2, op.sel_sha3, op.illegal}) :
                {op.sel_aes, op.sel_sha2, op.sel_sha3, op.illegal} == 4'b0000)
            else $error("asi_decode: class selects not exclusive");
    end

endmodule

/* hdl/asi_sha3.sv */
`timescale 1ns/10ps

module asi_sha3 (
    input  asi_pkg::asi_op_t         op,
    input  logic [asi_pkg::XLEN-1:0] rs1,           // x coordinate source
    input  logic [asi_pkg::XLEN-1:0] rs2,           // y coordinate source
    input  logic [1:0]               shamt,         // Post shift
    output logic [asi_pkg::XLEN-1:0] result
);
    import asi_pkg::*;

    // 16 is 1 mod 5, so the nibbles of a word just add up
    function automatic logic [2:0] mod5_word(input logic [XL:0] v);
        logic [6:0] acc;
        acc = '0;
        for (int i = 0; i < XLEN / 4; i++) begin
            acc = acc + 7'(v[4*i +: 4]);
        end
        return 3'(acc % 7'd5);
    endfunction

    logic [2:0] x_base;                             // rs1 mod 5
    logic [2:0] y_base;                             // rs2 mod 5
    logic [2:0] x_off;                              // 0, 1, 2 or 4
    logic [2:0] x_sel;                              // Offset x mod 5
    logic [4:0] yx_sum;                             // 2x + 3y, at most 20
    logic [2:0] yx_hi;
    logic [4:0] idx;                                // Lane 0..24
    logic [7:0] idx_sh;

    assign x_base = mod5_word(rs1);
    assign y_base = mod5_word(rs2);
    // One-hot bits land on binary weights 1, 2, 4
    assign x_off  = {op.sha3_fn[SHA3_FN_X4], op.sha3_fn[SHA3_FN_X2], op.sha3_fn[SHA3_FN_X1]};
    assign x_sel  = 3'((5'(x_base) + 5'(x_off)) % 5'd5);
    assign yx_sum = 5'(x_base) * 5'd2 + 5'(y_base) * 5'd3;
    assign yx_hi  = 3'(yx_sum % 5'd5);

    assign idx    = op.sha3_fn[SHA3_FN_YX] ? 5'(y_base) + 5'd5 * 5'(yx_hi)
                                           : 5'(x_sel) + 5'd5 * 5'(y_base);
    assign idx_sh = 8'(idx) << shamt;               // Scale to byte offset
    assign result = op.sel_sha3 ? XLEN'(idx_sh) : '0;

endmodule

/* hdl/asi_sha256.sv */
`timescale 1ns/10ps

module asi_sha256 (
    input  asi_pkg::asi_op_t         op,
    input  logic [asi_pkg::XLEN-1:0] rs1,
    output logic [asi_pkg::XLEN-1:0] result
);
    import asi_pkg::*;

    function automatic logic [XL:0] ror(input logic [XL:0] v, input int n);
        return (v >> n) | (v << (XLEN - n));
    endfunction

    logic [XL:0] src;                               // Gated operand

    assign src = {XLEN{op.sel_sha2}} & rs1;         // Quiet when unused

    // ----------------------------------------------------------
    // Sigma functions
    // ----------------------------------------------------------
    always_comb begin
        case (op.sha2_ss)
            2'd0: result = ror(src, 7)  ^ ror(src, 18) ^ (src >> 3);   // sigma0
            2'd1: result = ror(src, 17) ^ ror(src, 19) ^ (src >> 10);  // sigma1
            2'd2: result = ror(src, 2)  ^ ror(src, 13) ^ ror(src, 22); // Sum0
            2'd3: result = ror(src, 6)  ^ ror(src, 11) ^ ror(src, 25); // Sum1
        endcase
    end

endmodule

/* hdl/asi_aes.sv */
`timescale 1ns/10ps

module asi_aes #(
    parameter int SBOX_LANES = 1                    // Bytes substituted per cycle
) (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     flush,         // Abort op in progress
    input  asi_pkg::asi_op_t         op,
    input  logic [asi_pkg::XLEN-1:0] rs1,           // One column, byte 0 low
    output logic                     ready,
    output logic [asi_pkg::XLEN-1:0] result
);
    import asi_pkg::*;

    localparam logic [1:0] LAST_STEP = 2'(4 / SBOX_LANES - 1);

    // ----------------------------------------------------------
    // GF(2^8) arithmetic, modulus x^8 + x^4 + x^3 + x + 1
    // ----------------------------------------------------------
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // a^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);                   // a^(2^i)
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    function automatic logic [7:0] sub_byte(input logic [7:0] b, input logic dec);
        logic [7:0] t;
        if (dec) begin
            t = rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05;     // Inverse affine
            return gf_inv(t);
        end
        t = gf_inv(b);
        return t ^ rotl8(t, 1) ^ rotl8(t, 2) ^ rotl8(t, 3) ^ rotl8(t, 4) ^ 8'h63;
    endfunction

    // Row i takes coefficient (j - i) mod 4 for byte j
    function automatic logic [XL:0] mix_col(input logic [XL:0] col, input logic dec);
        logic [31:0] coef;
        logic [7:0]  acc;
        logic [XL:0] res;
        coef = dec ? 32'h090d0b0e : 32'h01010302;   // {c3 c2 c1 c0}
        res  = '0;
        for (int i = 0; i < 4; i++) begin
            acc = '0;
            for (int j = 0; j < 4; j++) begin
                acc = acc ^ gf_mul(coef[8*((j - i) & 3) +: 8], col[8*j +: 8]);
            end
            res[8*i +: 8] = acc;
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // Step control and lanes
    // ----------------------------------------------------------
    logic [1:0]  cnt;                               // Steps done so far
    logic        busy;                              // Result register complete
    logic [XL:0] res_q;
    logic [1:0]  base;                              // First byte of this step
    logic        last;                              // Final step of the op
    logic [7:0]  lane_out [SBOX_LANES];

    assign base   = 2'(cnt * SBOX_LANES);
    assign last   = op.aes_mix || (cnt == LAST_STEP);   // Mix is one step
    assign ready  = busy && !flush;
    assign result = res_q;

    for (genvar k = 0; k < SBOX_LANES; k++) begin : g_lane
        assign lane_out[k] = sub_byte(rs1[8*(base + k) +: 8], op.aes_dec);
    end

    always_ff @(posedge g_clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (flush || busy) begin
            busy <= 1'b0;                           // Abort, or ready cycle passed
            cnt  <= '0;
        end else if (op.sel_aes) begin
            busy <= last;
            cnt  <= last ? 2'd0 : cnt + 2'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (op.sel_aes && !busy) begin
            if (op.aes_mix) begin
                res_q <= mix_col(rs1, op.aes_dec);  // Whole column at once
            end else begin
                for (int k = 0; k < SBOX_LANES; k++) begin
                    res_q[8*(base + k) +: 8] <= lane_out[k];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_lanes: assert property (@(posedge g_clk) SBOX_LANES inside {1, 2, 4})
        else $error("asi_aes: SBOX_LANES must be 1, 2 or 4");
    a_ready_sel: assert property (@(posedge g_clk) disable iff (!rst_n)
            ready |-> op.sel_aes && $past(op.sel_aes))
        else $error("asi_aes: ready without a held AES op");
    a_ready_flush: assert property (@(posedge g_clk) disable iff (!rst_n) flush |-> !ready)
        else $error("asi_aes: ready during flush");

endmodule

/* hdl/asi_result.sv */
`timescale 1ns/10ps

module asi_result (
    input  asi_pkg::asi_op_t         op,
    input  logic                     aes_ready,     // AES result register done
    input  logic [asi_pkg::XLEN-1:0] aes_result,
    input  logic [asi_pkg::XLEN-1:0] sha2_result,
    input  logic [asi_pkg::XLEN-1:0] sha3_result,
    output logic                     ready,
    output logic [asi_pkg::XLEN-1:0] result
);
    import asi_pkg::*;

    // ----------------------------------------------------------
    // AND-OR select, illegal falls through as zero
    // ----------------------------------------------------------
    assign result = ({XLEN{op.sel_aes}}  & aes_result)  |
                    ({XLEN{op.sel_sha2}} & sha2_result) |
                    ({XLEN{op.sel_sha3}} & sha3_result);

    // Combinational classes finish in the valid cycle
    assign ready = op.sel_sha2 ||
                   op.sel_sha3 ||
                   op.illegal  ||
                   (op.sel_aes && aes_ready);       // Multi-cycle class

endmodule

/* hdl/asi_top.sv */
`timescale 1ns/10ps

module asi_top #(
    parameter int SBOX_LANES = 1                    // AES S-box lanes, 1, 2 or 4
) (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     asi_valid,     // Held until asi_ready
    input  logic                     asi_flush,     // Abort AES op
    input  asi_pkg::asi_uop_t        asi_uop,
    input  logic [asi_pkg::XLEN-1:0] asi_rs1,
    input  logic [asi_pkg::XLEN-1:0] asi_rs2,
    input  logic [1:0]               asi_shamt,     // SHA3 post shift
    output logic                     asi_ready,
    output logic [asi_pkg::XLEN-1:0] asi_result
);
    import asi_pkg::*;

    asi_op_t     op;                                // Decoded controls
    logic        aes_ready;
    logic [XL:0] aes_result;
    logic [XL:0] sha2_result;
    logic [XL:0] sha3_result;

    // ----------------------------------------------------------
    // Decode, execute, select
    // ----------------------------------------------------------
    asi_decode u_decode (
        .valid (asi_valid),
        .uop   (asi_uop),
        .op    (op)
    );

    asi_sha3 u_sha3 (
        .op     (op),
        .rs1    (asi_rs1),
        .rs2    (asi_rs2),
        .shamt  (asi_shamt),
        .result (sha3_result)
    );

    asi_sha256 u_sha256 (
        .op     (op),
        .rs1    (asi_rs1),
        .result (sha2_result)
    );

    asi_aes #(
        .SBOX_LANES (SBOX_LANES)
    ) u_aes (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .flush  (asi_flush),
        .op     (op),
        .rs1    (asi_rs1),
        .ready  (aes_ready),
        .result (aes_result)
    );

    asi_result u_result (
        .op          (op),
        .aes_ready   (aes_ready),
        .aes_result  (aes_result),
        .sha2_result (sha2_result),
        .sha3_result (sha3_result),
        .ready       (asi_ready),
        .result      (asi_result)
    );

endmodule

/* sim/asi_tb.sv */
`timescale 1ns/10ps

module asi_tb;
    import asi_pkg::*;

    localparam int LANES   = 2;                     // S-box lanes in the DUT
    localparam int SUB_LAT = 4 / LANES;             // Cycles for one SubBytes
    localparam int TIMEOUT = 20;                    // Cycles to wait for ready

    logic        g_clk;
    logic        rst_n;
    logic        asi_valid;
    logic        asi_flush;
    asi_uop_t    asi_uop;
    logic [31:0] asi_rs1;
    logic [31:0] asi_rs2;
    logic [1:0]  asi_shamt;
    logic        asi_ready;
    logic [31:0] asi_result;

    string       test_name;                         // Name of the running test
    logic [31:0] exp_result;
    int          exp_lat;                           // Valid cycles before ready
    int          lat_cnt;
    logic [31:0] lcg_state = 32'd58;
    logic [7:0]  sbox_tab [256];                    // Forward S-box model
    logic [7:0]  isbox_tab [256];
    asi_uop_t    sha3_ops [5];
    asi_uop_t    bad_ops [5];
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;

    asi_top #(
        .SBOX_LANES (LANES)
    ) UUT (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .asi_valid  (asi_valid),
        .asi_flush  (asi_flush),
        .asi_uop    (asi_uop),
        .asi_rs1    (asi_rs1),
        .asi_rs2    (asi_rs2),
        .asi_shamt  (asi_shamt),
        .asi_ready  (asi_ready),
        .asi_result (asi_result)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                  // 4 ns period
    end

    // Counts held valid cycles and clears on ready or idle
    always_ff @(posedge g_clk) begin
        if (!rst_n || !asi_valid || asi_ready) begin
            lat_cnt <= 0;
        end else begin
            lat_cnt <= lat_cnt + 1;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_result: assert property (@(posedge g_clk) disable iff (!rst_n)
            asi_valid && asi_ready |-> asi_result == exp_result)
        else stop_on_error($sformatf("mismatch %s expected %h actual %h", test_name,
            $sampled(exp_result), $sampled(asi_result)));
    a_latency: assert property (@(posedge g_clk) disable iff (!rst_n)
            asi_valid && asi_ready |-> lat_cnt == exp_lat)
        else stop_on_error($sformatf("mismatch %s latency expected %0d actual %0d",
            test_name, $sampled(exp_lat), $sampled(lat_cnt)));
    a_idle: assert property (@(posedge g_clk) disable iff (!rst_n) !asi_valid |-> !asi_ready)
        else stop_on_error("ready was high while valid was low");
    a_flush: assert property (@(posedge g_clk) disable iff (!rst_n) asi_flush |-> !asi_ready)
        else stop_on_error($sformatf("ready was high in a flush cycle of %s", test_name));

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // ----------------------------------------------------------
    // Models
    // ----------------------------------------------------------
    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Horner form with the MSB of b first
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
            if (b[i]) begin
                p = p ^ a;
            end
        end
        return p;
    endfunction

    // Inverse by search and then the textbook affine bit formula
    task automatic build_sbox();
        logic [7:0] inv;
        logic [7:0] s;
        for (int a = 0; a < 256; a++) begin
            inv = 8'h00;
            for (int b = 1; b < 256; b++) begin
                if (gmul(8'(a), 8'(b)) == 8'h01) begin
                    inv = 8'(b);
                end
            end
            for (int i = 0; i < 8; i++) begin
                s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^
                       inv[(i + 6) % 8] ^ inv[(i + 7) % 8] ^ 8'h63 >> i;
            end
            sbox_tab[a]  = s;
            isbox_tab[s] = 8'(a);                   // Table inverted
        end
    endtask

    function automatic logic [31:0] sub_model(input logic [31:0] w, input logic dec);
        logic [31:0] o;
        for (int i = 0; i < 4; i++) begin
            o[8*i +: 8] = dec ? isbox_tab[w[8*i +: 8]] : sbox_tab[w[8*i +: 8]];
        end
        return o;
    endfunction

    function automatic logic [31:0] mix_model(input logic [31:0] w, input logic dec);
        logic [7:0]  k [4];
        logic [31:0] o;
        if (dec) begin
            k = '{8'h0e, 8'h0b, 8'h0d, 8'h09};     // Inverse matrix row
        end else begin
            k = '{8'h02, 8'h03, 8'h01, 8'h01};
        end
        for (int i = 0; i < 4; i++) begin
            o[8*i +: 8] = gmul(k[0], w[8*i +: 8])             ^
                          gmul(k[1], w[8*((i + 1) % 4) +: 8]) ^
                          gmul(k[2], w[8*((i + 2) % 4) +: 8]) ^
                          gmul(k[3], w[8*((i + 3) % 4) +: 8]);
        end
        return o;
    endfunction

    function automatic logic [31:0] rotr(input logic [31:0] w, input int n);
        return 32'({w, w} >> n);
    endfunction

    function automatic logic [31:0] sigma_model(input int ss, input logic [31:0] w);
        case (ss)
            0:       return rotr(w, 7)  ^ rotr(w, 18) ^ (w >> 3);
            1:       return rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
            2:       return rotr(w, 2)  ^ rotr(w, 13) ^ rotr(w, 22);
            default: return rotr(w, 6)  ^ rotr(w, 11) ^ rotr(w, 25);
        endcase
    endfunction

    // fn 0..4 is xy, x1, x2, x4, yx
    function automatic logic [31:0] lane_model(input int fn, input logic [31:0] a,
                                               input logic [31:0] b, input logic [1:0] sh);
        longint off;
        longint idx;
        off = (fn == 3) ? 4 : (fn == 4) ? 0 : fn;
        if (fn == 4) begin
            idx = longint'(b) % 5 + 5 * ((2 * longint'(a) + 3 * longint'(b)) % 5);
        end else begin
            idx = (longint'(a) + off) % 5 + 5 * (longint'(b) % 5);
        end
        return 32'(idx) << sh;
    endfunction

    // ----------------------------------------------------------
    // One transaction with valid held until ready
    // ----------------------------------------------------------
    task automatic run_op(input string name, input asi_uop_t uop, input logic [31:0] a,
                          input logic [31:0] b, input logic [1:0] sh,
                          input logic [31:0] exp, input int lat, input int flush_cyc,
                          output logic [31:0] res);
        logic got;
        got = 1'b0;
        @(posedge g_clk);
        asi_valid  <= 1'b1;
        asi_uop    <= uop;
        asi_rs1    <= a;
        asi_rs2    <= b;
        asi_shamt  <= sh;
        asi_flush  <= 1'b0;
        test_name  <= name;
        exp_result <= exp;
        exp_lat    <= lat;
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge g_clk);                       // Ready settled here
            if (asi_ready) begin
                got = 1'b1;
                break;
            end
            @(posedge g_clk);
            asi_flush <= (n + 1 == flush_cyc);      // One flush cycle
        end
        if (!got) stop_on_error($sformatf("ready never came for %s", name));
        res = asi_result;
        @(posedge g_clk);
        asi_valid <= 1'b0;
        asi_flush <= 1'b0;
    endtask

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        asi_valid  = 1'b0;
        asi_flush  = 1'b0;
        asi_uop    = '0;
        asi_rs1    = '0;
        asi_rs2    = '0;
        asi_shamt  = '0;
        test_name  = "reset";
        exp_result = '0;
        exp_lat    = 0;
        sha3_ops   = '{ASI_SHA3_XY, ASI_SHA3_X1, ASI_SHA3_X2, ASI_SHA3_X4, ASI_SHA3_YX};
        bad_ops    = '{7'h00, 7'h1f, {ASI_CLS_SHA2, 5'd4}, {ASI_CLS_SHA3, 5'd7},
                       {ASI_CLS_AES, 5'b00100}};
        build_sbox();
        repeat (4) @(posedge g_clk);
        rst_n <= 1'b1;

        for (int fn = 0; fn < 5; fn++) begin        // Lane index for every shift
            for (int sh = 0; sh < 4; sh++) begin
                x = next_rand();
                y = next_rand();
                run_op($sformatf("sha3_fn%0d_sh%0d", fn, sh), sha3_ops[fn], x, y, 2'(sh),
                       lane_model(fn, x, y, 2'(sh)), 0, 0, r);
            end
        end
        for (int ss = 0; ss < 4; ss++) begin
            repeat (4) begin
                x = next_rand();
                run_op($sformatf("sha256_s%0d", ss), {ASI_CLS_SHA2, 5'(ss)}, x, '0, 2'd0,
                       sigma_model(ss, x), 0, 0, r);
            end
        end
        repeat (4) begin                            // SubBytes both ways and round trip
            x = next_rand();
            y = next_rand();
            run_op("aes_encs", ASI_AES_ENCS, x, '0, 2'd0, sub_model(x, 1'b0), SUB_LAT, 0, r);
            run_op("aes_decs_back", ASI_AES_DECS, r, '0, 2'd0, x, SUB_LAT, 0, r);
            run_op("aes_decs", ASI_AES_DECS, y, '0, 2'd0, sub_model(y, 1'b1), SUB_LAT, 0, r);
        end
        repeat (4) begin                            // MixColumns both ways and round trip
            x = next_rand();
            y = next_rand();
            run_op("aes_encm", ASI_AES_ENCM, x, '0, 2'd0, mix_model(x, 1'b0), 1, 0, r);
            run_op("aes_decm_back", ASI_AES_DECM, r, '0, 2'd0, x, 1, 0, r);
            run_op("aes_decm", ASI_AES_DECM, y, '0, 2'd0, mix_model(y, 1'b1), 1, 0, r);
        end
        for (int i = 0; i < 5; i++) begin
            run_op($sformatf("illegal_%0d", i), bad_ops[i], next_rand(), next_rand(), 2'd3,
                   '0, 0, 0, r);
        end
        repeat (5) @(posedge g_clk);                // Idle so ready must stay low
        x = next_rand();
        run_op("aes_encs_flush", ASI_AES_ENCS, x, '0, 2'd0, sub_model(x, 1'b0),
               2 + SUB_LAT, 1, r);                  // Flushed in cycle 1 and restarted
        y = next_rand();
        run_op("aes_decs_flush", ASI_AES_DECS, y, '0, 2'd0, sub_model(y, 1'b1),
               2 * SUB_LAT + 1, SUB_LAT, r);        // Flushed in the cycle ready would rise

        repeat (3) @(posedge g_clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sources.f */
hdl/asi_pkg.sv
hdl/asi_decode.sv
hdl/asi_sha3.sv
hdl/asi_sha256.sv
hdl/asi_aes.sv
hdl/asi_result.sv
hdl/asi_top.sv
sim/asi_tb.sv

/* Bender.yml */
package:
  name: asi_unit

sources:
  - files:
      - hdl/asi_pkg.sv
      - hdl/asi_decode.sv
      - hdl/asi_sha3.sv
      - hdl/asi_sha256.sv
      - hdl/asi_aes.sv
      - hdl/asi_result.sv
      - hdl/asi_top.sv
  - target: simulation
    files:
      - sim/asi_tb.sv
